//--- run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module csr_unit_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vcsr_unit_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

//--- src/csr_counters.sv
// Counters are writable through the machine addresses only; a write suppresses that increment
module csr_counters (
    input logic clk,
    input logic rst,
    input csr_pkg::csr_write_t csr_write,
    input csr_pkg::retire_cnt_t retire_count,
    output csr_pkg::counters_t counters
);

    csr_pkg::counter_t mcycle;
    csr_pkg::counter_t minstret;

    // Replace one half on a write, otherwise add the increment
    function automatic csr_pkg::counter_t next_count(
        input csr_pkg::counter_t cur,
        input logic wr_lo,
        input logic wr_hi,
        input csr_pkg::csr_data_t value,
        input csr_pkg::counter_t inc
    );
        if (wr_lo)
            return {cur[63:32], value};
        if (wr_hi)
            return {value, cur[31:0]};
        return cur + inc;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= next_count(mcycle,
                                 csr_write.en && (csr_write.addr == csr_pkg::ADDR_MCYCLE),
                                 csr_write.en && (csr_write.addr == csr_pkg::ADDR_MCYCLEH),
                                 csr_write.value, 64'd1);
            minstret <= next_count(minstret,
                                   csr_write.en && (csr_write.addr == csr_pkg::ADDR_MINSTRET),
                                   csr_write.en && (csr_write.addr == csr_pkg::ADDR_MINSTRETH),
                                   csr_write.value, 64'(retire_count));
        end
    end

    assign counters = '{mcycle: mcycle, minstret: minstret};

endmodule

//--- src/csr_pkg.sv
// Fixed M+U mode configuration with 32-bit XLEN; no supervisor mode, no vectored mtvec
package csr_pkg;

    ////////////////////////////////////////
    // Widths
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [63:0] counter_t;
    typedef logic [4:0] ecode_t;
    typedef logic [2:0] id_t;
    typedef logic [1:0] retire_cnt_t;

    // CSR op, taken from fn3[1:0]
    typedef logic [1:0] csr_op_t;
    localparam csr_op_t CSR_RW = 2'd1;
    localparam csr_op_t CSR_RS = 2'd2;
    localparam csr_op_t CSR_RC = 2'd3;

    typedef enum logic [1:0] {
        PRIV_USER = 2'b00,
        PRIV_MACHINE = 2'b11
    } privilege_t;

    // Address bits [11:10] of a read-only CSR
    localparam logic [1:0] CSR_READ_ONLY = 2'b11;

    ////////////////////////////////////////
    // Addresses
    localparam csr_addr_t ADDR_MSTATUS = 12'h300;
    localparam csr_addr_t ADDR_MISA = 12'h301;
    localparam csr_addr_t ADDR_MIE = 12'h304;
    localparam csr_addr_t ADDR_MTVEC = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE = 12'h342;
    localparam csr_addr_t ADDR_MTVAL = 12'h343;
    localparam csr_addr_t ADDR_MIP = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    localparam csr_addr_t ADDR_CYCLE = 12'hC00;
    localparam csr_addr_t ADDR_INSTRET = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH = 12'hC82;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID = 12'hF14;

    // mstatus field positions, MPP is the low bit of a 2-bit field
    localparam int MSTATUS_MIE = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP = 11;
    localparam int MSTATUS_MPRV = 17;

    // Machine interrupt codes, also their bit positions in mip and mie
    localparam ecode_t INT_SOFTWARE = 5'd3;
    localparam ecode_t INT_TIMER = 5'd7;
    localparam ecode_t INT_EXTERNAL = 5'd11;

    ////////////////////////////////////////
    // Constant registers and masks
    // MXL=1, extensions I, M and U
    localparam csr_data_t MISA_VALUE = 32'h4010_1100;
    localparam csr_data_t MIMPID_VALUE = 32'd1;
    localparam csr_data_t MHARTID_VALUE = 32'd0;
    localparam csr_data_t RESET_MTVEC = 32'h8000_0000;
    localparam csr_data_t MSTATUS_W_MASK = 32'h0002_1888;
    localparam csr_data_t EXC_LEGAL = 32'h0000_095D;
    localparam csr_data_t INT_LEGAL = 32'h0000_0888;

    ////////////////////////////////////////
    // Structs
    typedef struct packed {
        csr_addr_t addr;
        csr_op_t op;
        logic writes;
        csr_data_t data;
    } csr_request_t;

    typedef struct packed {
        logic en;
        csr_addr_t addr;
        csr_data_t value;
    } csr_write_t;

    typedef struct packed {
        logic valid;
        ecode_t code;
        csr_data_t pc;
        csr_data_t tval;
    } trap_event_t;

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } irq_lines_t;

    typedef struct packed {
        csr_data_t mstatus;
        csr_data_t mie;
        csr_data_t mip;
        csr_data_t mtvec;
        csr_data_t mepc;
        csr_data_t mcause;
        csr_data_t mtval;
        csr_data_t mscratch;
    } trap_csr_t;

    typedef struct packed {
        counter_t mcycle;
        counter_t minstret;
    } counters_t;

endpackage

//--- src/csr_read_modify.sv
// Unknown addresses read zero; only machine-level, writable addresses produce a write
module csr_read_modify (
    input logic clk,
    input logic rst,
    input logic commit,
    input csr_pkg::csr_request_t req,
    input csr_pkg::trap_csr_t trap_csrs,
    input csr_pkg::counters_t counters,
    output csr_pkg::csr_data_t rd_value,
    output csr_pkg::csr_write_t csr_write
);

    csr_pkg::csr_data_t selected;
    csr_pkg::csr_data_t updated;
    logic write_allowed;
    logic write_en_r;
    csr_pkg::csr_addr_t write_addr_r;
    csr_pkg::csr_data_t write_value_r;

    ////////////////////////////////////////
    // Read mux
    always_comb begin
        case (req.addr)
            csr_pkg::ADDR_MISA: selected = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID: selected = '0;
            csr_pkg::ADDR_MIMPID: selected = csr_pkg::MIMPID_VALUE;
            csr_pkg::ADDR_MHARTID: selected = csr_pkg::MHARTID_VALUE;
            csr_pkg::ADDR_MSTATUS: selected = trap_csrs.mstatus;
            csr_pkg::ADDR_MIE: selected = trap_csrs.mie;
            csr_pkg::ADDR_MIP: selected = trap_csrs.mip;
            csr_pkg::ADDR_MTVEC: selected = trap_csrs.mtvec;
            csr_pkg::ADDR_MEPC: selected = trap_csrs.mepc;
            csr_pkg::ADDR_MCAUSE: selected = trap_csrs.mcause;
            csr_pkg::ADDR_MTVAL: selected = trap_csrs.mtval;
            csr_pkg::ADDR_MSCRATCH: selected = trap_csrs.mscratch;
            // User aliases share the machine counters
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_CYCLE: selected = counters.mcycle[31:0];
            csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_CYCLEH: selected = counters.mcycle[63:32];
            csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_INSTRET: selected = counters.minstret[31:0];
            csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_INSTRETH:
                selected = counters.minstret[63:32];
            default: selected = '0;
        endcase
    end

    ////////////////////////////////////////
    // Read-modify-write
    always_comb begin
        case (req.op)
            csr_pkg::CSR_RS: updated = selected | req.data;
            csr_pkg::CSR_RC: updated = selected & ~req.data;
            default: updated = req.data;
        endcase
    end

    // Privilege field [9:8] must be machine, access field [11:10] not read-only
    assign write_allowed = req.writes
                         && (req.addr[9:8] == csr_pkg::PRIV_MACHINE)
                         && (req.addr[11:10] != csr_pkg::CSR_READ_ONLY);

    always_ff @(posedge clk) begin
        if (rst)
            write_en_r <= 1'b0;
        else
            write_en_r <= commit & write_allowed;
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            rd_value <= selected;
            write_addr_r <= req.addr;
            write_value_r <= updated;
        end
    end

    assign csr_write = '{en: write_en_r, addr: write_addr_r, value: write_value_r};

endmodule

//--- src/csr_sequencer.sv
// One CSR instruction in flight; new_request must only be raised while ready is high
module csr_sequencer (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic [2:0] fn3,
    input csr_pkg::csr_data_t rs1_value,
    input logic [4:0] rs1_addr,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::id_t id,
    input csr_pkg::id_t oldest_id,
    input logic ack,
    output logic ready,
    output logic processing_csr,
    output logic done,
    output logic commit,
    output csr_pkg::id_t wb_id,
    output csr_pkg::csr_request_t req
);

    logic busy;
    logic commit_in_progress;
    csr_pkg::csr_request_t req_in;

    // Immediate form takes the rs1 field zero-extended
    always_comb begin
        req_in.addr = addr;
        req_in.op = fn3[1:0];
        req_in.data = fn3[2] ? {27'd0, rs1_addr} : rs1_value;
        // Set or clear with a zero source is read-only
        req_in.writes = (req_in.op == csr_pkg::CSR_RW) || (rs1_addr != 5'd0);
    end

    assign ready = ~busy;
    assign processing_csr = busy | new_request;

    always_ff @(posedge clk) begin
        if (new_request) begin
            req <= req_in;
            wb_id <= id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            commit_in_progress <= 1'b0;
            done <= 1'b0;
        end else begin
            busy <= (busy & ~ack) | new_request;
            commit_in_progress <= (commit_in_progress & ~new_request) | commit;
            done <= (done & ~ack) | commit;
        end
    end

    // Fires once, when this instruction becomes the oldest in flight
    assign commit = busy & (oldest_id == wb_id) & ~commit_in_progress;

endmodule

//--- src/csr_trap_regs.sv
// Trap strobes and an mstatus write are never active together; mepc assumes no C extension
module csr_trap_regs (
    input logic clk,
    input logic rst,
    input csr_pkg::csr_write_t csr_write,
    input csr_pkg::trap_event_t exception,
    input logic mret,
    input logic interrupt_taken,
    input csr_pkg::irq_lines_t irq,
    output csr_pkg::trap_csr_t trap_csrs,
    output csr_pkg::privilege_t privilege,
    output logic interrupt_pending,
    output csr_pkg::csr_data_t exception_target_pc,
    output csr_pkg::csr_data_t epc
);

    localparam int MPP = csr_pkg::MSTATUS_MPP;

    csr_pkg::csr_data_t mstatus, mstatus_wr, mstatus_next;
    csr_pkg::csr_data_t mie, mip, mip_next, mtvec, mepc, mcause, mtval, mscratch;
    csr_pkg::privilege_t privilege_next;
    csr_pkg::ecode_t irq_cause;
    csr_pkg::csr_data_t irq_masked;
    logic trap;
    logic mcause_legal;

    function automatic logic hit(input csr_pkg::csr_write_t w, input csr_pkg::csr_addr_t a);
        return w.en && (w.addr == a);
    endfunction

    assign trap = exception.valid | interrupt_taken;

    ////////////////////////////////////////
    // Privilege and mstatus
    always_comb begin
        mstatus_wr = (mstatus & ~csr_pkg::MSTATUS_W_MASK)
                   | (csr_write.value & csr_pkg::MSTATUS_W_MASK);
        // No supervisor level, an unsupported mpp keeps its old value
        if (mstatus_wr[MPP +: 2] inside {2'b01, 2'b10})
            mstatus_wr[MPP +: 2] = mstatus[MPP +: 2];
    end

    always_comb begin
        mstatus_next = mstatus;
        privilege_next = privilege;
        if (trap) begin
            mstatus_next[csr_pkg::MSTATUS_MPIE] = mstatus[csr_pkg::MSTATUS_MIE];
            mstatus_next[csr_pkg::MSTATUS_MIE] = 1'b0;
            mstatus_next[MPP +: 2] = privilege;
            privilege_next = csr_pkg::PRIV_MACHINE;
        end else if (mret) begin
            privilege_next = csr_pkg::privilege_t'(mstatus[MPP +: 2]);
            mstatus_next[csr_pkg::MSTATUS_MIE] = mstatus[csr_pkg::MSTATUS_MPIE];
            mstatus_next[csr_pkg::MSTATUS_MPIE] = 1'b1;
            mstatus_next[MPP +: 2] = csr_pkg::PRIV_USER;
            if (mstatus[MPP +: 2] != csr_pkg::PRIV_MACHINE)
                mstatus_next[csr_pkg::MSTATUS_MPRV] = 1'b0;
        end else if (hit(csr_write, csr_pkg::ADDR_MSTATUS)) begin
            mstatus_next = mstatus_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= csr_pkg::PRIV_MACHINE;
            mstatus <= {19'd0, csr_pkg::PRIV_MACHINE, 11'd0};
        end else begin
            privilege <= privilege_next;
            mstatus <= mstatus_next;
        end
    end

    ////////////////////////////////////////
    // Trap vector, return pc, trap value and scratch
    always_ff @(posedge clk) begin
        if (rst)
            mtvec <= csr_pkg::RESET_MTVEC;
        else if (hit(csr_write, csr_pkg::ADDR_MTVEC))
            mtvec <= {csr_write.value[31:2], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (trap)
            mepc <= {exception.pc[31:2], 2'b00};
        else if (hit(csr_write, csr_pkg::ADDR_MEPC))
            mepc <= {csr_write.value[31:2], 2'b00};
        if (exception.valid)
            mtval <= exception.tval;
        else if (hit(csr_write, csr_pkg::ADDR_MTVAL))
            mtval <= csr_write.value;
        if (hit(csr_write, csr_pkg::ADDR_MSCRATCH))
            mscratch <= csr_write.value;
    end

    ////////////////////////////////////////
    // Interrupts
    always_comb begin
        mip_next = '0;
        mip_next[csr_pkg::INT_SOFTWARE] = irq.software;
        mip_next[csr_pkg::INT_TIMER] = irq.timer;
        mip_next[csr_pkg::INT_EXTERNAL] = irq.external;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
            mie <= '0;
        end else begin
            mip <= mip_next;
            if (hit(csr_write, csr_pkg::ADDR_MIE))
                mie <= csr_write.value & csr_pkg::INT_LEGAL;
        end
    end

    assign irq_masked = mip & mie;
    assign interrupt_pending = (|irq_masked) & mstatus[csr_pkg::MSTATUS_MIE];

    // Priority: external, software, timer
    always_ff @(posedge clk) begin
        if (interrupt_pending)
            irq_cause <= irq_masked[csr_pkg::INT_EXTERNAL] ? csr_pkg::INT_EXTERNAL :
                         irq_masked[csr_pkg::INT_SOFTWARE] ? csr_pkg::INT_SOFTWARE :
                         csr_pkg::INT_TIMER;
    end

    ////////////////////////////////////////
    // mcause, sparse codes checked against the legal masks
    assign mcause_legal = csr_write.value[31] ? csr_pkg::INT_LEGAL[csr_write.value[4:0]]
                                              : csr_pkg::EXC_LEGAL[csr_write.value[4:0]];

    always_ff @(posedge clk) begin
        if (rst)
            mcause <= '0;
        else if (interrupt_taken)
            mcause <= {1'b1, 26'd0, irq_cause};
        else if (exception.valid)
            mcause <= {1'b0, 26'd0, exception.code};
        else if (hit(csr_write, csr_pkg::ADDR_MCAUSE) && mcause_legal)
            mcause <= {csr_write.value[31], 26'd0, csr_write.value[4:0]};
    end

    assign trap_csrs = '{mstatus: mstatus, mie: mie, mip: mip, mtvec: mtvec, mepc: mepc,
                         mcause: mcause, mtval: mtval, mscratch: mscratch};
    assign exception_target_pc = mtvec;
    assign epc = mepc;

endmodule

//--- src/csr_unit.sv
// CSR unit for an M+U core; at most one trap strobe per cycle, none during an mstatus write
module csr_unit (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic [2:0] fn3,
    input csr_pkg::csr_data_t rs1_value,
    input logic [4:0] rs1_addr,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::id_t id,
    input csr_pkg::id_t oldest_id,
    input logic ack,
    input csr_pkg::trap_event_t exception,
    input logic mret,
    input logic interrupt_taken,
    input csr_pkg::irq_lines_t irq,
    input csr_pkg::retire_cnt_t retire_count,
    output logic ready,
    output logic processing_csr,
    output logic done,
    output csr_pkg::id_t wb_id,
    output csr_pkg::csr_data_t rd_value,
    output csr_pkg::privilege_t privilege,
    output logic interrupt_pending,
    output csr_pkg::csr_data_t exception_target_pc,
    output csr_pkg::csr_data_t epc
);

    logic commit;
    csr_pkg::csr_request_t req;
    csr_pkg::csr_write_t csr_write;
    csr_pkg::trap_csr_t trap_csrs;
    csr_pkg::counters_t counters;

    csr_sequencer seq0 (.clk, .rst, .new_request, .fn3, .rs1_value, .rs1_addr, .addr, .id,
                        .oldest_id, .ack, .ready, .processing_csr, .done, .commit, .wb_id, .req);

    csr_read_modify rmw0 (.clk, .rst, .commit, .req, .trap_csrs, .counters, .rd_value,
                          .csr_write);

    csr_trap_regs trap0 (.clk, .rst, .csr_write, .exception, .mret, .interrupt_taken, .irq,
                         .trap_csrs, .privilege, .interrupt_pending, .exception_target_pc,
                         .epc);

    csr_counters cnt0 (.clk, .rst, .csr_write, .retire_count, .counters);

endmodule

//--- verif/csr_unit_sva.sv
// Bound into csr_unit; checks trap strobe exclusivity, request rules and done after reset
module csr_unit_sva (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic ready,
    input logic done,
    input csr_pkg::trap_event_t exception,
    input logic mret,
    input logic interrupt_taken
);

    // At most one trap strobe per cycle
    strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({exception.valid, mret, interrupt_taken}))
        else $error("trap strobes overlap");

    request_needs_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready)
        else $error("new_request raised while not ready");

    done_low_after_reset: assert property (@(posedge clk) rst |=> !done)
        else $error("done high in the cycle after reset");

endmodule

bind csr_unit csr_unit_sva sva0 (.*);

//--- verif/csr_unit_tb.sv
// Drives csr_unit through CSR ops, traps, interrupts and counters; retire_count idles at zero
module csr_unit_tb;

    logic clk;
    logic rst;
    logic new_request;
    logic [2:0] fn3;
    csr_pkg::csr_data_t rs1_value;
    logic [4:0] rs1_addr;
    csr_pkg::csr_addr_t addr;
    csr_pkg::id_t id;
    csr_pkg::id_t oldest_id;
    logic ack;
    csr_pkg::trap_event_t exception;
    logic mret;
    logic interrupt_taken;
    csr_pkg::irq_lines_t irq;
    csr_pkg::retire_cnt_t retire_count;
    logic ready;
    logic processing_csr;
    logic done;
    csr_pkg::id_t wb_id;
    csr_pkg::csr_data_t rd_value;
    csr_pkg::privilege_t privilege;
    logic interrupt_pending;
    csr_pkg::csr_data_t exception_target_pc;
    csr_pkg::csr_data_t epc;

    csr_unit dut0 (.*);

    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    logic [31:0] lfsr = 32'h5b2c;
    csr_pkg::id_t next_id = '0;
    csr_pkg::csr_data_t exp_q[$];
    logic chk_q[$];

    ////////////////////////////////////////
    // Reference model state
    csr_pkg::csr_data_t m_mstatus, m_mie, m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch;
    logic [1:0] m_priv;
    logic [63:0] m_minstret;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Expected read value of a CSR
    function automatic csr_pkg::csr_data_t ref_read(input csr_pkg::csr_addr_t a);
        case (a)
            12'h301: return 32'h4010_1100;
            12'hF13: return 32'd1;
            12'h300: return m_mstatus;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'hB02, 12'hC02: return m_minstret[31:0];
            12'hB82, 12'hC82: return m_minstret[63:32];
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic cause_legal(input csr_pkg::csr_data_t v);
        if (v[31])
            return v[4:0] inside {5'd3, 5'd7, 5'd11};
        return v[4:0] inside {5'd0, 5'd2, 5'd3, 5'd4, 5'd6, 5'd8, 5'd11};
    endfunction

    task automatic model_write(input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t v);
        csr_pkg::csr_data_t n;
        case (a)
            12'h300: begin
                // mie, mpie, mpp and mprv are writable
                n = (m_mstatus & ~32'h0002_1888) | (v & 32'h0002_1888);
                if (n[12:11] inside {2'b01, 2'b10})
                    n[12:11] = m_mstatus[12:11];
                m_mstatus = n;
            end
            12'h304: m_mie = v & 32'h0000_0888;
            12'h305: m_mtvec = {v[31:2], 2'b00};
            12'h340: m_mscratch = v;
            12'h341: m_mepc = {v[31:2], 2'b00};
            12'h342: if (cause_legal(v)) m_mcause = {v[31], 26'd0, v[4:0]};
            12'h343: m_mtval = v;
            12'hB02: m_minstret[31:0] = v;
            12'hB82: m_minstret[63:32] = v;
            default: ;
        endcase
    endtask

    task automatic check_value(input csr_pkg::csr_data_t got, input csr_pkg::csr_data_t exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Bounded handshake waits
    task automatic wait_ready();
        for (int t = 0; t < 50 && !ready; t++)
            @(negedge clk);
        if (!ready) begin
            $display("timeout at %0t: ready never came back", $time);
            timeouts++;
        end
    endtask

    task automatic wait_done();
        for (int t = 0; t < 50 && !done; t++)
            @(negedge clk);
        if (!done) begin
            $display("timeout at %0t: done never rose", $time);
            timeouts++;
        end
    endtask

    task automatic do_csr(input csr_pkg::csr_op_t op, input logic imm, input logic [4:0] rs,
                          input csr_pkg::csr_data_t val, input csr_pkg::csr_addr_t a,
                          input logic chk);
        csr_pkg::csr_data_t operand;
        csr_pkg::csr_data_t old;
        csr_pkg::csr_data_t result;
        logic wr;
        int dly;
        operand = imm ? {27'd0, rs} : val;
        wr = (op == csr_pkg::CSR_RW) || (rs != 5'd0);
        wait_ready();
        old = ref_read(a);
        exp_q.push_back(old);
        chk_q.push_back(chk);
        new_request = 1'b1;
        fn3 = {imm, op};
        rs1_value = val;
        rs1_addr = rs;
        addr = a;
        id = next_id;
        oldest_id = next_id + 3'd1;
        dly = rand_bits(2);
        @(negedge clk);
        check_value(32'({ready, processing_csr}), 32'b01, "ready and processing_csr when busy");
        new_request = 1'b0;
        // Instruction becomes oldest after a random delay
        repeat (dly) @(negedge clk);
        oldest_id = next_id;
        wait_done();
        check_value(32'(wb_id), 32'(next_id), "wb_id");
        ack = 1'b1;
        @(negedge clk);
        ack = 1'b0;
        check_value(32'({ready, processing_csr}), 32'b10, "ready and processing_csr after ack");
        next_id++;
        case (op)
            csr_pkg::CSR_RS: result = old | operand;
            csr_pkg::CSR_RC: result = old & ~operand;
            default: result = operand;
        endcase
        if (wr && a[9:8] == 2'b11 && a[11:10] != 2'b11)
            model_write(a, result);
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t a);
        do_csr(csr_pkg::CSR_RS, 1'b1, 5'd0, 32'd0, a, 1'b1);
    endtask

    task automatic trap_entry(input csr_pkg::csr_data_t pc);
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
        m_mstatus[12:11] = m_priv;
        m_priv = 2'b11;
        m_mepc = {pc[31:2], 2'b00};
    endtask

    task automatic do_mret();
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        m_priv = m_mstatus[12:11];
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        if (m_mstatus[12:11] != 2'b11)
            m_mstatus[17] = 1'b0;
        m_mstatus[12:11] = 2'b00;
        check_value(32'(privilege), 32'(m_priv), "privilege after mret");
    endtask

    ////////////////////////////////////////
    // Comparing process checks one value per done
    always @(negedge clk) begin
        csr_pkg::csr_data_t e;
        logic c;
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                $display("done raised at %0t with no request outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                c = chk_q.pop_front();
                if (c)
                    check_value(rd_value, e, "rd_value");
            end
        end
    end

    initial begin
        csr_pkg::csr_data_t v;
        csr_pkg::csr_data_t pc;
        logic [4:0] code;
        logic [2:0] lines;
        logic [31:0] sum;
        csr_pkg::csr_op_t op;
        logic imm;
        rst = 1'b1;
        new_request = 1'b0;
        fn3 = '0;
        rs1_value = '0;
        rs1_addr = '0;
        addr = '0;
        id = '0;
        oldest_id = '0;
        ack = 1'b0;
        exception = '0;
        mret = 1'b0;
        interrupt_taken = 1'b0;
        irq = '0;
        retire_count = '0;
        m_mstatus = 32'h0000_1800;
        m_mie = '0;
        m_mtvec = 32'h8000_0000;
        m_mcause = '0;
        m_mepc = '0;
        m_mtval = '0;
        m_mscratch = '0;
        m_priv = 2'b11;
        m_minstret = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value(32'({ready, done, interrupt_pending}), 32'b100, "flags after reset");
        check_value(32'(privilege), 32'h3, "privilege after reset");
        check_value(exception_target_pc, 32'h8000_0000, "mtvec after reset");

        // Registers without reset get known values first
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd1, rand_bits(32), 12'h340, 1'b0);
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd1, rand_bits(32), 12'h341, 1'b0);
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd1, rand_bits(32), 12'h343, 1'b0);

        // Read-modify-write on mscratch with some zero sources
        for (int i = 0; i < 16; i++) begin
            op = rand_bits(2);
            if (op == 2'd0)
                op = csr_pkg::CSR_RW;
            imm = rand_bits(1);
            v = rand_bits(32);
            do_csr(op, imm, (i % 4 == 3) ? 5'd0 : rand_bits(5), v, 12'h340, 1'b1);
            read_csr(12'h340);
        end

        // mcause legality and constants
        for (int i = 0; i < 10; i++) begin
            v = rand_bits(32);
            // Every other write carries code 11, legal for both exceptions and interrupts
            if (i % 2 == 1)
                v[4:0] = 5'd11;
            do_csr(csr_pkg::CSR_RW, 1'b0, 5'd2, v, 12'h342, 1'b1);
            read_csr(12'h342);
        end
        read_csr(12'h301);
        read_csr(12'hF14);
        read_csr(12'hF13);
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd3, rand_bits(32), 12'h7C0, 1'b1);
        read_csr(12'h7C0);

        // Exception and mret from user level
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd4, rand_bits(32), 12'h305, 1'b1);
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd4, rand_bits(32) & ~32'h1800, 12'h300, 1'b1);
        do_mret();
        for (int i = 0; i < 4; i++) begin
            code = rand_bits(3) % 7;
            code = (code < 3) ? {code[3:0], 1'b0} : (code == 3) ? 5'd3 :
                   (code == 4) ? 5'd6 : (code == 5) ? 5'd8 : 5'd11;
            pc = rand_bits(32);
            v = rand_bits(32);
            exception = '{valid: 1'b1, code: code, pc: pc, tval: v};
            @(negedge clk);
            exception = '0;
            trap_entry(pc);
            m_mcause = {27'd0, code};
            m_mtval = v;
            check_value(32'(privilege), 32'h3, "privilege after exception");
            check_value(epc, m_mepc, "epc");
            check_value(exception_target_pc, m_mtvec, "exception_target_pc");
            read_csr(12'h341);
            read_csr(12'h342);
            read_csr(12'h343);
            read_csr(12'h300);
            do_mret();
        end

        // Interrupts from machine level
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd4, 32'h0000_1800, 12'h300, 1'b1);
        do_mret();
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd5, rand_bits(32), 12'h304, 1'b1);
        do_csr(csr_pkg::CSR_RS, 1'b1, 5'd8, 32'd0, 12'h300, 1'b1);
        for (int i = 0; i < 8; i++) begin
            lines = rand_bits(3);
            irq = lines;
            @(negedge clk);
            check_value(32'(interrupt_pending),
                        32'(|({lines[1], lines[2], lines[0]} &
                              {m_mie[7], m_mie[3], m_mie[11]}) & m_mstatus[3]),
                        "interrupt_pending");
        end
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd5, 32'h0000_0888, 12'h304, 1'b1);
        lines = rand_bits(3) | 3'b001 << rand_bits(2) % 3;
        irq = lines;
        repeat (2) @(negedge clk);
        check_value(32'(interrupt_pending), 32'd1, "interrupt_pending before take");
        pc = rand_bits(32);
        exception = '{valid: 1'b0, code: 5'd0, pc: pc, tval: 32'd0};
        interrupt_taken = 1'b1;
        @(negedge clk);
        interrupt_taken = 1'b0;
        exception = '0;
        irq = '0;
        trap_entry(pc);
        // Priority external, software, timer
        m_mcause = {1'b1, 26'd0, lines[0] ? 5'd11 : lines[2] ? 5'd3 : 5'd7};
        read_csr(12'h342);
        read_csr(12'h341);
        read_csr(12'h300);

        // Retired counter
        do_csr(csr_pkg::CSR_RW, 1'b0, 5'd6, rand_bits(32), 12'hB02, 1'b1);
        sum = '0;
        for (int i = 0; i < 12; i++) begin
            retire_count = rand_bits(2) % 3;
            sum += retire_count;
            @(negedge clk);
        end
        retire_count = '0;
        m_minstret += 64'(sum);
        read_csr(12'hB02);
        read_csr(12'hC82);

        wait_ready();
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && exp_q.size() == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- vlog.f
src/csr_pkg.sv
src/csr_sequencer.sv
src/csr_read_modify.sv
src/csr_trap_regs.sv
src/csr_counters.sv
src/csr_unit.sv
verif/csr_unit_sva.sv
verif/csr_unit_tb.sv
